// File: design/apb_clause_port.sv
// **********************************************************************
// APB slave: break value staging, clause commit, status and result
// **********************************************************************

`timescale 1ns/1ps

module apb_clause_port import walk_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [APB_AW-1:0] paddr_i,
    input  logic [APB_DW-1:0] pwdata_i,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    clause_if.source          push_if,
    input  logic              queue_full_i,
    input  logic              res_valid_i,
    input  logic [FLIP_W-1:0] res_flip_i,
    input  logic              res_random_i,
    output logic              res_ack_o
);

    apb_op_e            op;
    logic               commit_ok;
    logic [1:0]         brk_sel;
    logic [BREAK_W-1:0] brk_q [NSAT];
    logic               push_valid_q;
    logic               res_valid_q;
    logic [FLIP_W-1:0]  res_flip_q;
    logic               res_random_q;

    assign pready_o = 1'b1;
    assign brk_sel  = paddr_i[3:2];

    // decode only in the access phase
    always_comb begin
        op = NONE;
        if (psel_i && penable_i) begin
            case (paddr_i)
                REG_BREAK0, REG_BREAK1, REG_BREAK2: op = STAGE;
                REG_COMMIT: op = pwrite_i ? COMMIT : NONE;
                REG_STATUS: op = pwrite_i ? NONE : READ_STATUS;
                REG_RESULT: op = pwrite_i ? NONE : READ_RESULT;
                default:    op = BAD_ADDR;
            endcase
        end
    end

    // a commit is refused when it cannot land in the queue
    assign commit_ok = (op == COMMIT) && !queue_full_i && !push_valid_q;
    assign pslverr_o = (op == BAD_ADDR) || ((op == COMMIT) && !commit_ok);

    always_comb begin
        prdata_o = '0;
        case (op)
            STAGE:       prdata_o[BREAK_W-1:0] = pwrite_i ? '0 : brk_q[brk_sel];
            READ_STATUS: prdata_o[1:0] = {queue_full_i, res_valid_q};
            READ_RESULT: prdata_o[3:0] = {res_valid_q, res_random_q, res_flip_q};
            default:     prdata_o = '0;
        endcase
    end

    // staged break values
    always_ff @(posedge clk) begin
        if (op == STAGE && pwrite_i) begin
            brk_q[brk_sel] <= pwdata_i[BREAK_W-1:0];
        end
    end

    assign push_if.valid  = push_valid_q;
    assign push_if.break0 = brk_q[0];
    assign push_if.break1 = brk_q[1];
    assign push_if.break2 = brk_q[2];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            push_valid_q <= 1'b0;
        end else if (commit_ok) begin
            push_valid_q <= 1'b1;
        end else if (push_if.ready) begin
            push_valid_q <= 1'b0;
        end
    end

    // single result slot, emptied by a REG_RESULT read
    assign res_ack_o = !res_valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_valid_q  <= 1'b0;
            res_flip_q   <= '0;
            res_random_q <= 1'b0;
        end else if (res_valid_i && res_ack_o) begin
            res_valid_q  <= 1'b1;
            res_flip_q   <= res_flip_i;
            res_random_q <= res_random_i;
        end else if (op == READ_RESULT) begin
            res_valid_q <= 1'b0;
        end
    end

endmodule

// File: design/clause_if.sv
// **********************************************************************
// clause record with valid/ready handshake
// **********************************************************************

`timescale 1ns/1ps

interface clause_if import walk_pkg::*; ();

    logic               valid;
    logic               ready;
    logic [BREAK_W-1:0] break0;
    logic [BREAK_W-1:0] break1;
    logic [BREAK_W-1:0] break2;

    // record moves on an edge where valid and ready are both high
    modport source (
        output valid, break0, break1, break2,
        input  ready
    );

    modport sink (
        input  valid, break0, break1, break2,
        output ready
    );

endinterface

// File: design/clause_queue.sv
// **********************************************************************
// four-entry FIFO of clause records
// **********************************************************************

`timescale 1ns/1ps

module clause_queue import walk_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    clause_if.sink   wr_if,
    clause_if.source rd_if,
    output logic     full_o
);

    logic [NSAT-1:0][BREAK_W-1:0] mem [QUEUE_DEPTH];
    logic [QUEUE_AW-1:0]          wr_ptr_q;
    logic [QUEUE_AW-1:0]          rd_ptr_q;
    logic [QUEUE_AW:0]            count_q;
    logic                         push;
    logic                         pop;

    assign full_o      = (count_q == (QUEUE_AW + 1)'(QUEUE_DEPTH));
    assign wr_if.ready = !full_o;
    assign rd_if.valid = (count_q != '0);

    assign push = wr_if.valid && wr_if.ready;
    assign pop  = rd_if.valid && rd_if.ready;

    // head record
    assign rd_if.break0 = mem[rd_ptr_q][0];
    assign rd_if.break1 = mem[rd_ptr_q][1];
    assign rd_if.break2 = mem[rd_ptr_q][2];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= {wr_if.break2, wr_if.break1, wr_if.break0};
        end
    end

    // pointers wrap on their own at depth 4
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// File: design/heuristic_selector.sv
// **********************************************************************
// flip choice: zero override, random walk, greedy minimum break value
// **********************************************************************

`timescale 1ns/1ps

module heuristic_selector import walk_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    clause_if.sink            clause_if,
    input  logic [RAND_W-1:0] rnd_word_i,
    output logic              rnd_step_o,
    output logic              res_valid_o,
    output logic [FLIP_W-1:0] res_flip_o,
    output logic              res_random_o,
    input  logic              res_ack_i
);

    sel_state_e         state_q;
    logic [FLIP_W-1:0]  scan_idx_q;
    logic               zero_seen_q;
    logic [BREAK_W-1:0] brk_q [NSAT];
    logic [RAND_W-1:0]  rnd_q;
    logic [BREAK_W-1:0] min_val_q;
    logic [FLIP_W-1:0]  min_idx_q;
    logic               accept;
    logic [BREAK_W-1:0] cur_brk;
    logic               walk;
    logic [FLIP_W-1:0]  walk_idx;

    assign clause_if.ready = (state_q == IDLE);
    assign accept          = clause_if.valid && clause_if.ready;
    assign rnd_step_o      = accept;
    assign cur_brk         = brk_q[scan_idx_q];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            scan_idx_q  <= '0;
            zero_seen_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q     <= SCAN;
                        scan_idx_q  <= '0;
                        zero_seen_q <= 1'b0;
                    end
                end
                SCAN: begin
                    if (cur_brk == '0) begin
                        zero_seen_q <= 1'b1;
                    end
                    if (scan_idx_q == FLIP_W'(NSAT - 1)) begin
                        state_q <= DECIDE;
                    end
                    scan_idx_q <= scan_idx_q + 1'b1;
                end
                DECIDE: state_q <= res_ack_i ? IDLE : HOLD;
                HOLD: begin
                    if (res_ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // running minimum; <= lets a later index take a tie
    always_ff @(posedge clk) begin
        if (accept) begin
            brk_q[0]  <= clause_if.break0;
            brk_q[1]  <= clause_if.break1;
            brk_q[2]  <= clause_if.break2;
            rnd_q     <= rnd_word_i;
            min_val_q <= '1;
        end else if (state_q == SCAN && cur_brk <= min_val_q) begin
            min_val_q <= cur_brk;
            min_idx_q <= scan_idx_q;
        end
    end

    // a zero is also the minimum, so the highest zero is min_idx_q
    assign walk     = (rnd_q < WALK_P);
    assign walk_idx = (rnd_q[1:0] == 2'd3) ? 2'd2 : rnd_q[1:0];

    always_comb begin
        res_flip_o   = min_idx_q;
        res_random_o = 1'b0;
        if (!zero_seen_q && walk) begin
            res_flip_o   = walk_idx;
            res_random_o = 1'b1;
        end
    end

    assign res_valid_o = (state_q == DECIDE) || (state_q == HOLD);

endmodule

// File: design/walk_lfsr.sv
// **********************************************************************
// 32-bit galois LFSR, one step per accepted clause
// **********************************************************************

`timescale 1ns/1ps

module walk_lfsr import walk_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              step_i,
    output logic [RAND_W-1:0] word_o
);

    logic [RAND_W-1:0] lfsr_q;
    logic [RAND_W-1:0] lfsr_next;

    // shift right, fold the taps back in when the lsb is set
    assign lfsr_next = (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : '0);
    assign word_o    = lfsr_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            lfsr_q <= LFSR_SEED;
        end else if (step_i) begin
            lfsr_q <= lfsr_next;
        end
    end

endmodule

// File: design/walk_pkg.sv
// **********************************************************************
// shared widths, APB register map, walk threshold, LFSR constants
// and the selector state and port opcode enums
// **********************************************************************

package walk_pkg;

    // clause shape, fixed at 3-SAT
    localparam int NSAT    = 3;
    localparam int BREAK_W = 5;
    localparam int FLIP_W  = 2;
    localparam int RAND_W  = 32;

    // clause queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_AW    = 2;

    // about a 1 in 16 chance of a random walk
    localparam logic [RAND_W-1:0] WALK_P = 32'h0FFF_FFFF;

    // galois LFSR, taps 32 22 2 1
    localparam logic [RAND_W-1:0] LFSR_SEED = 32'h1D87_2B41;
    localparam logic [RAND_W-1:0] LFSR_TAPS = 32'h8020_0003;

    // APB bus
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] REG_BREAK0 = 8'h00;
    localparam logic [APB_AW-1:0] REG_BREAK1 = 8'h04;
    localparam logic [APB_AW-1:0] REG_BREAK2 = 8'h08;
    localparam logic [APB_AW-1:0] REG_COMMIT = 8'h0C;
    localparam logic [APB_AW-1:0] REG_STATUS = 8'h10;
    localparam logic [APB_AW-1:0] REG_RESULT = 8'h14;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DECIDE,
        HOLD
    } sel_state_e;

    typedef enum logic [2:0] {
        NONE,
        STAGE,
        COMMIT,
        READ_STATUS,
        READ_RESULT,
        BAD_ADDR
    } apb_op_e;

endpackage

// File: design/walksat_select_top.sv
// **********************************************************************
// flip-choice stage: APB port, clause FIFO, LFSR and selector
// **********************************************************************

`timescale 1ns/1ps

module walksat_select_top import walk_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [APB_AW-1:0] paddr_i,
    input  logic [APB_DW-1:0] pwdata_i,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o
);

    logic              queue_full;
    logic              res_valid;
    logic [FLIP_W-1:0] res_flip;
    logic              res_random;
    logic              res_ack;
    logic [RAND_W-1:0] rnd_word;
    logic              rnd_step;

    // port to queue, queue to selector
    clause_if push_if ();
    clause_if pop_if ();

    apb_clause_port u_port (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .push_if      (push_if.source),
        .queue_full_i (queue_full),
        .res_valid_i  (res_valid),
        .res_flip_i   (res_flip),
        .res_random_i (res_random),
        .res_ack_o    (res_ack)
    );

    clause_queue u_queue (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wr_if   (push_if.sink),
        .rd_if   (pop_if.source),
        .full_o  (queue_full)
    );

    walk_lfsr u_lfsr (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .step_i  (rnd_step),
        .word_o  (rnd_word)
    );

    heuristic_selector u_sel (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .clause_if    (pop_if.sink),
        .rnd_word_i   (rnd_word),
        .rnd_step_o   (rnd_step),
        .res_valid_o  (res_valid),
        .res_flip_o   (res_flip),
        .res_random_o (res_random),
        .res_ack_i    (res_ack)
    );

endmodule

// File: dv/tb_clk_gen.sv
// **********************************************************************
// testbench clock source, 100 ns period
// **********************************************************************

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);

    // half period of 50 ns
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

endmodule

// File: dv/walksat_select_assert.sv
// **********************************************************************
// concurrent checks on APB phasing, clause handshakes and result hold
// **********************************************************************

`timescale 1ns/1ps

module walksat_select_assert import walk_pkg::*; (
    input logic                      clk,
    input logic                      rst_n_i,
    input logic                      psel_i,
    input logic                      penable_i,
    input logic                      pop_valid_i,
    input logic                      pop_ready_i,
    input logic [NSAT*BREAK_W-1:0]   pop_rec_i,
    input logic                      res_valid_i,
    input logic                      res_ack_i
);

    // access phase must follow a setup phase
    a_penable_setup: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(penable_i) |-> psel_i && $past(psel_i))
        else $error("penable rose without a preceding setup cycle");

    a_pop_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (pop_valid_i && !pop_ready_i) |=> (pop_valid_i && $stable(pop_rec_i)))
        else $error("queue to selector record changed while stalled");

    // selector keeps its result until the port takes it
    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (res_valid_i && !res_ack_i) |=> res_valid_i)
        else $error("res_valid dropped before res_ack");

endmodule

bind walksat_select_top walksat_select_assert u_assert (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pop_valid_i  (pop_if.valid),
    .pop_ready_i  (pop_if.ready),
    .pop_rec_i    ({pop_if.break2, pop_if.break1, pop_if.break0}),
    .res_valid_i  (res_valid),
    .res_ack_i    (res_ack)
);

// File: dv/walksat_select_tb.sv
// **********************************************************************
// testbench: APB tasks, stimulus LFSR, reference model of the flip
// choice, result comparison and reporting
// **********************************************************************

`timescale 1ns/1ps

module walksat_select_tb import walk_pkg::*; ();

    localparam int N_ZERO   = 40;
    localparam int N_GREEDY = 60;
    localparam int N_WALK   = 200;
    // result register, selector hold stage and the four queue slots
    localparam int BP_ACCEPTED = QUEUE_DEPTH + 2;
    localparam int POLL_LIMIT  = 20;
    localparam int N_CLAUSES   = N_ZERO + N_GREEDY + N_WALK + BP_ACCEPTED + 1;
    // about 12 accesses per clause, 3 cycles each, twice over
    localparam int TIMEOUT_CYCLES = (N_CLAUSES + 8) * 12 * 3 * 2;
    localparam logic [RAND_W-1:0] STIM_SEED  = 32'h0cea_9b59;
    // galois form of taps 32 22 2 1
    localparam logic [RAND_W-1:0] MODEL_TAPS = 32'h8020_0003;

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;

    logic [RAND_W-1:0] stim_state = STIM_SEED;
    logic [RAND_W-1:0] model_word = LFSR_SEED;
    logic [2:0]        exp_q [$];
    logic [APB_DW-1:0] got_result;
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;
    event              result_read;

    tb_clk_gen u_clk (
        .clk_o (clk)
    );

    walksat_select_top uut (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    // fibonacci LFSR, one step per bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = stim_state[31] ^ stim_state[21] ^ stim_state[1] ^ stim_state[0];
            stim_state = {stim_state[30:0], fb};
            v = {v[6:0], fb};
        end
        return v;
    endfunction

    function automatic logic [BREAK_W-1:0] nonzero_break();
        logic [BREAK_W-1:0] v;
        v = BREAK_W'(rand_bits(BREAK_W));
        if (v == '0) begin
            v = 1;
        end
        return v;
    endfunction

    function automatic logic [RAND_W-1:0] model_next(input logic [RAND_W-1:0] s);
        return (s >> 1) ^ (s[0] ? MODEL_TAPS : '0);
    endfunction

    // expected {random, flip}
    function automatic logic [2:0] predict(input logic [BREAK_W-1:0] b0,
                                           input logic [BREAK_W-1:0] b1,
                                           input logic [BREAK_W-1:0] b2,
                                           input logic [RAND_W-1:0] word);
        logic [BREAK_W-1:0] brk [NSAT];
        logic [FLIP_W-1:0]  pick;
        brk[0] = b0;
        brk[1] = b1;
        brk[2] = b2;
        // highest zero wins outright
        for (int i = NSAT - 1; i >= 0; i--) begin
            if (brk[i] == '0) begin
                return {1'b0, FLIP_W'(i)};
            end
        end
        if (word < WALK_P) begin
            pick = (word[1:0] == 2'd3) ? 2'd2 : word[1:0];
            return {1'b1, pick};
        end
        pick = 0;
        for (int i = 1; i < NSAT; i++) begin
            if (brk[i] <= brk[pick]) begin
                pick = FLIP_W'(i);
            end
        end
        return {1'b0, pick};
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic apb_access(input logic write, input logic [APB_AW-1:0] addr,
                              input logic [APB_DW-1:0] wdata,
                              output logic [APB_DW-1:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic commit_clause(input logic [BREAK_W-1:0] b0, input logic [BREAK_W-1:0] b1,
                                 input logic [BREAK_W-1:0] b2,
                                 output logic err, output logic [2:0] pred);
        logic [APB_DW-1:0] rd;
        apb_access(1'b1, REG_BREAK0, APB_DW'(b0), rd, err);
        apb_access(1'b1, REG_BREAK1, APB_DW'(b1), rd, err);
        apb_access(1'b1, REG_BREAK2, APB_DW'(b2), rd, err);
        apb_access(1'b1, REG_COMMIT, '0, rd, err);
        pred = predict(b0, b1, b2, model_word);
        // a refused clause never reaches the selector
        if (!err) begin
            exp_q.push_back(pred);
            model_word = model_next(model_word);
        end
    endtask

    task automatic fetch_result();
        logic [APB_DW-1:0] rd;
        logic              err;
        int                polls;
        polls = 0;
        rd    = '0;
        while (!rd[0] && polls < POLL_LIMIT) begin
            apb_access(1'b0, REG_STATUS, '0, rd, err);
            polls++;
        end
        checks++;
        assert (rd[0]) else begin
            $display("no result became ready within %0d status reads at %0t", POLL_LIMIT, $time);
            errors++;
        end
        if (rd[0]) begin
            apb_access(1'b0, REG_RESULT, '0, got_result, err);
            -> result_read;
        end
    endtask

    always @(result_read) begin
        logic [2:0] exp;
        checks++;
        assert (exp_q.size() != 0) else begin
            $display("a result came back with no clause outstanding at %0t", $time);
            errors++;
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            check_value("result valid", got_result[3], 1);
            check_value("flip index", got_result[1:0], exp[1:0]);
            check_value("random flag", got_result[2], exp[2]);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [BREAK_W-1:0] b0;
        logic [BREAK_W-1:0] b1;
        logic [BREAK_W-1:0] b2;
        logic [2:0]         mask;
        logic [2:0]         pred;
        logic [APB_DW-1:0]  rd;
        logic               err;
        int                 errs_before;
        int                 count;
        rst_n   <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // unmapped addresses and an empty result slot
        errs_before = errors;
        apb_access(1'b0, 8'h18, '0, rd, err);
        check_value("pslverr on unmapped read", err, 1);
        apb_access(1'b1, 8'h40, 32'h5, rd, err);
        check_value("pslverr on unmapped write", err, 1);
        apb_access(1'b0, REG_RESULT, '0, rd, err);
        check_value("result valid with nothing pending", rd[3], 0);
        check_value("pslverr on result read", err, 0);
        check_value("pready", pready, 1);
        $display("test error_response: %0d errors", errors - errs_before);

        errs_before = errors;
        for (int n = 0; n < N_ZERO; n++) begin
            b0   = nonzero_break();
            b1   = nonzero_break();
            b2   = nonzero_break();
            mask = 3'(rand_bits(3));
            if (mask == '0) begin
                mask = 3'b001;
            end
            if (mask[0]) b0 = '0;
            if (mask[1]) b1 = '0;
            if (mask[2]) b2 = '0;
            commit_clause(b0, b1, b2, err, pred);
            check_value("commit pslverr", err, 0);
            fetch_result();
        end
        $display("test zero_override: %0d clauses, %0d errors", N_ZERO, errors - errs_before);

        // every third clause ties f0 with f1, the next with f2
        errs_before = errors;
        count = 0;
        for (int n = 0; n < N_GREEDY; n++) begin
            b0 = BREAK_W'(rand_bits(4)) + 1'b1;
            b1 = nonzero_break();
            b2 = nonzero_break();
            if (n % 3 == 1) begin
                b1 = b0;
                b2 = b0 + 1'b1 + BREAK_W'(rand_bits(3));
            end else if (n % 3 == 2) begin
                b2 = b0;
                b1 = b0 + 1'b1 + BREAK_W'(rand_bits(3));
            end
            commit_clause(b0, b1, b2, err, pred);
            check_value("commit pslverr", err, 0);
            if (!pred[2]) count++;
            fetch_result();
        end
        $display("test greedy_min: %0d greedy of %0d clauses, %0d errors", count, N_GREEDY,
                 errors - errs_before);

        errs_before = errors;
        count = 0;
        for (int n = 0; n < N_WALK; n++) begin
            commit_clause(nonzero_break(), nonzero_break(), nonzero_break(), err, pred);
            check_value("commit pslverr", err, 0);
            if (pred[2]) count++;
            fetch_result();
        end
        checks++;
        assert (count > 0) else begin
            $display("no random walk occurred in %0d clauses", N_WALK);
            errors++;
        end
        $display("test random_walk: %0d walks in %0d clauses, %0d errors", count, N_WALK,
                 errors - errs_before);

        // fill every stage without reading, the last commit must bounce
        errs_before = errors;
        for (int n = 0; n <= BP_ACCEPTED; n++) begin
            commit_clause(nonzero_break(), nonzero_break(), nonzero_break(), err, pred);
            check_value("back-pressure commit pslverr", err, (n == BP_ACCEPTED) ? 1 : 0);
        end
        apb_access(1'b0, REG_STATUS, '0, rd, err);
        check_value("status queue full", rd[1], 1);
        check_value("status result valid", rd[0], 1);
        for (int n = 0; n < BP_ACCEPTED; n++) begin
            fetch_result();
        end
        for (int n = 0; n < 8; n++) begin
            apb_access(1'b0, REG_STATUS, '0, rd, err);
            check_value("status valid after drain", rd[0], 0);
        end
        check_value("status queue full after drain", rd[1], 0);
        apb_access(1'b0, REG_RESULT, '0, rd, err);
        check_value("result valid after drain", rd[3], 0);
        check_value("outstanding clauses", exp_q.size(), 0);
        $display("test backpressure: %0d accepted, %0d errors", BP_ACCEPTED,
                 errors - errs_before);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: files.f
design/walk_pkg.sv
design/clause_if.sv
design/apb_clause_port.sv
design/clause_queue.sv
design/walk_lfsr.sv
design/heuristic_selector.sv
design/walksat_select_top.sv
dv/tb_clk_gen.sv
dv/walksat_select_assert.sv
dv/walksat_select_tb.sv
